// File: common/wb_pkg.sv
package wb_pkg;

   // Bus vectors
   typedef logic [31:0] wb_adr_t;
   typedef logic [31:0] wb_dat_t;
   typedef logic [3:0]  wb_sel_t;

   // Port width code of one address region
   typedef logic [1:0] region_w_t;

   // Eight width fields, region 0 in bits 15:14
   typedef logic [15:0] width_map_t;

   typedef enum logic [2:0]
   {
      OP_READ,
      OP_WRITE,
      OP_BLK_READ,
      OP_BLK_WRITE,
      OP_RMW
   } wb_op_e;

   typedef enum logic [1:0]
   {
      ST_OK,
      ST_ERR,
      ST_RTY,
      ST_BADWIDTH
   } wb_status_e;

   // One command from the requester
   typedef struct packed
   {
      wb_op_e  op;
      wb_adr_t adr;
      wb_dat_t dat;
      wb_sel_t sel;
      logic    last;   // closes a block cycle
   } wb_cmd_t;

   typedef struct packed
   {
      wb_dat_t    rdata;
      wb_status_e status;
   } wb_rsp_t;

   // Master to slave
   typedef struct packed
   {
      wb_adr_t adr;
      wb_dat_t dat;
      wb_sel_t sel;
      logic    cyc;
      logic    stb;
      logic    we;
   } wb_m2s_t;

   // Slave to master
   typedef struct packed
   {
      wb_dat_t dat;
      logic    ack;
      logic    err;
      logic    rty;
   } wb_s2m_t;

   // Width codes
   localparam region_w_t RW_8  = 2'b00;
   localparam region_w_t RW_16 = 2'b01;
   localparam region_w_t RW_32 = 2'b10;
   localparam region_w_t RW_64 = 2'b11;

   // Regions 0 to 7 from the top field down
   localparam width_map_t WIDTH_MAP_RST =
      {RW_32, RW_16, RW_32, RW_64, RW_8, RW_16, RW_32, RW_64};

   // Slave fault regions
   localparam logic [2:0] ERR_REGION = 3'd6;
   localparam logic [2:0] RTY_REGION = 3'd7;

   // Slave depth, word index from adr[9:2]
   localparam int MEM_WORDS = 256;

endpackage

// File: wb_master/wb_region_cfg.sv
`timescale 1ns/10ps

module wb_region_cfg
(
   input  logic               CLK_I,
   input  logic               RST_I,
   input  logic               cfg_we,
   input  wb_pkg::width_map_t cfg_map,
   input  wb_pkg::wb_adr_t    adr,
   output wb_pkg::region_w_t  width
);

   // Current region width map
   wb_pkg::width_map_t map_q;

   // Bit offset of the selected field
   logic [3:0] field_lsb;

   always_ff @(posedge CLK_I or posedge RST_I)
   begin
      if (RST_I)
      begin
         map_q <= wb_pkg::WIDTH_MAP_RST;
      end
      else if (cfg_we)
      begin
         map_q <= cfg_map;
      end
   end

   // Region 0 sits at the top, so the field for region r starts at 2*(7-r)
   // 7-r on three bits is just the inverse
   always_comb
   begin
      field_lsb = {~adr[31:29], 1'b0};
      width     = map_q[field_lsb +: 2];
   end

endmodule

// File: wb_master/wb_master.sv
`timescale 1ns/10ps

module wb_master
(
   input  logic              CLK_I,
   input  logic              RST_I,
   input  logic              cmd_req,
   input  wb_pkg::wb_cmd_t   cmd,
   output logic              cmd_ack,
   output wb_pkg::wb_rsp_t   rsp,
   input  wb_pkg::region_w_t width,
   output wb_pkg::wb_m2s_t   m2s,
   input  wb_pkg::wb_s2m_t   s2m
);

   typedef enum logic [2:0]
   {
      IDLE,     // no cycle open
      BEAT,     // STB out, waiting for the slave
      HOLD,     // block cycle open between beats
      RMW_WR,   // turn from read half to write half
      DONE      // cmd_ack high until req drops
   } state_e;

   state_e state;

   // Bus control
   logic cyc_q;
   logic stb_q;
   logic we_q;

   // Bus payload
   wb_pkg::wb_adr_t adr_q;
   wb_pkg::wb_dat_t dat_q;
   wb_pkg::wb_sel_t sel_q;

   // Command under way and its region width
   wb_pkg::wb_cmd_t   cmd_q;
   wb_pkg::region_w_t width_q;

   logic accept;
   logic bad_width;
   logic wr_op;
   logic beat_end;
   logic fault;
   logic rmw_turn;
   logic last_beat;

   // Narrow selects down to the port width
   function automatic wb_pkg::wb_sel_t steer_sel(wb_pkg::region_w_t w, wb_pkg::wb_sel_t sel);
      case (w)
         wb_pkg::RW_8:  return {3'b000, sel[0]};
         wb_pkg::RW_16: return {2'b00, sel[1:0]};
         default:       return sel;
      endcase
   endfunction

   // Copy the low byte or halfword across all lanes
   function automatic wb_pkg::wb_dat_t steer_dat(wb_pkg::region_w_t w, wb_pkg::wb_dat_t dat);
      case (w)
         wb_pkg::RW_8:  return {4{dat[7:0]}};
         wb_pkg::RW_16: return {2{dat[15:0]}};
         default:       return dat;
      endcase
   endfunction

   always_comb
   begin
      accept    = (state == IDLE || state == HOLD) && cmd_req && !cmd_ack;
      bad_width = width == wb_pkg::RW_64;
      wr_op     = cmd.op == wb_pkg::OP_WRITE || cmd.op == wb_pkg::OP_BLK_WRITE;
      // Beat terminated by any slave response under STB
      beat_end  = state == BEAT && stb_q && (s2m.ack || s2m.err || s2m.rty);
      fault     = s2m.err || s2m.rty;
      // Read half of RMW done, write half still to run
      rmw_turn  = cmd_q.op == wb_pkg::OP_RMW && !we_q;
      // Only block beats may leave CYC open
      last_beat = (cmd_q.op == wb_pkg::OP_BLK_READ || cmd_q.op == wb_pkg::OP_BLK_WRITE) ?
                  cmd_q.last : 1'b1;
      m2s       = '{adr: adr_q, dat: dat_q, sel: sel_q, cyc: cyc_q, stb: stb_q, we: we_q};
   end

   // FSM and bus control
   always_ff @(posedge CLK_I or posedge RST_I)
   begin
      if (RST_I)
      begin
         state   <= IDLE;
         cyc_q   <= 1'b0;
         stb_q   <= 1'b0;
         we_q    <= 1'b0;
         cmd_ack <= 1'b0;
      end
      else
      begin
         case (state)
            IDLE, HOLD:
            begin
               if (accept)
               begin
                  state <= BEAT;
                  // 64-bit region gets no STB at all
                  if (!bad_width)
                  begin
                     cyc_q <= 1'b1;
                     stb_q <= 1'b1;
                     we_q  <= wr_op;
                  end
               end
            end
            BEAT:
            begin
               if (!stb_q)
               begin
                  // Rejected command, answer right away
                  cmd_ack <= 1'b1;
                  state   <= DONE;
               end
               else if (beat_end)
               begin
                  stb_q <= 1'b0;
                  if (fault)
                  begin
                     cyc_q   <= 1'b0;
                     cmd_ack <= 1'b1;
                     state   <= DONE;
                  end
                  else if (rmw_turn)
                  begin
                     state <= RMW_WR;
                  end
                  else
                  begin
                     if (last_beat)
                     begin
                        cyc_q <= 1'b0;
                     end
                     cmd_ack <= 1'b1;
                     state   <= DONE;
                  end
               end
            end
            RMW_WR:
            begin
               // Write half, same CYC
               stb_q <= 1'b1;
               we_q  <= 1'b1;
               state <= BEAT;
            end
            DONE:
            begin
               if (!cmd_req)
               begin
                  cmd_ack <= 1'b0;
                  state   <= cyc_q ? HOLD : IDLE;
               end
            end
            default:
            begin
               state <= IDLE;
            end
         endcase
      end
   end

   // Payload and response
   always_ff @(posedge CLK_I)
   begin
      if (accept)
      begin
         cmd_q   <= cmd;
         width_q <= width;
         adr_q   <= cmd.adr;
         dat_q   <= steer_dat(width, cmd.dat);
         // Reads take all four lanes
         sel_q   <= wr_op ? steer_sel(width, cmd.sel) : 4'hF;
      end
      else if (state == RMW_WR)
      begin
         sel_q <= steer_sel(width_q, cmd_q.sel);
      end

      if (state == BEAT && !stb_q)
      begin
         rsp.rdata  <= '0;
         rsp.status <= wb_pkg::ST_BADWIDTH;
      end
      else if (beat_end)
      begin
         // Raw DAT_I, kept from the read half of RMW
         if (!we_q)
         begin
            rsp.rdata <= s2m.dat;
         end
         if (s2m.err)
         begin
            rsp.status <= wb_pkg::ST_ERR;
         end
         else if (s2m.rty)
         begin
            rsp.status <= wb_pkg::ST_RTY;
         end
         else
         begin
            rsp.status <= wb_pkg::ST_OK;
         end
      end
   end

endmodule

// File: verilog/wb_sram_slave.sv
`timescale 1ns/10ps

module wb_sram_slave
(
   input  logic            CLK_I,
   input  logic            RST_I,
   input  wb_pkg::wb_m2s_t m2s,
   output wb_pkg::wb_s2m_t s2m
);

   wb_pkg::wb_dat_t mem [wb_pkg::MEM_WORDS];

   // Set in the first STB cycle of a beat
   logic wait_q;

   logic hit;
   logic answer;
   logic in_err;
   logic in_rty;

   always_comb
   begin
      hit    = m2s.cyc && m2s.stb;
      answer = hit && wait_q;
      in_err = m2s.adr[31:29] == wb_pkg::ERR_REGION;
      in_rty = m2s.adr[31:29] == wb_pkg::RTY_REGION;
      // Word index from adr[9:2], all regions alias
      s2m    = '{dat: mem[m2s.adr[9:2]],
                 ack: answer && !in_err && !in_rty,
                 err: answer && in_err,
                 rty: answer && in_rty};
   end

   always_ff @(posedge CLK_I or posedge RST_I)
   begin
      if (RST_I)
      begin
         wait_q <= 1'b0;
         for (int w = 0; w < wb_pkg::MEM_WORDS; w++)
         begin
            mem[w] <= '0;
         end
      end
      else
      begin
         // Clears on the answering edge so the next beat waits again
         wait_q <= hit && !wait_q;
         // Fault regions never touch memory
         if (answer && m2s.we && !in_err && !in_rty)
         begin
            for (int b = 0; b < 4; b++)
            begin
               if (m2s.sel[b])
               begin
                  mem[m2s.adr[9:2]][8*b +: 8] <= m2s.dat[8*b +: 8];
               end
            end
         end
      end
   end

endmodule

// File: verilog/wb_subsys_top.sv
`timescale 1ns/10ps

module wb_subsys_top
(
   input  logic               CLK_I,
   input  logic               RST_I,
   input  logic               cfg_we,
   input  wb_pkg::width_map_t cfg_map,
   input  logic               cmd_req,
   input  wb_pkg::wb_cmd_t    cmd,
   output logic               cmd_ack,
   output wb_pkg::wb_rsp_t    rsp
);

   // Width of the pending command's region
   wb_pkg::region_w_t cmd_width;

   wb_pkg::wb_m2s_t m2s;
   wb_pkg::wb_s2m_t s2m;

   // Lookup on the command address
   wb_region_cfg u_cfg
   (
      .CLK_I   (CLK_I),
      .RST_I   (RST_I),
      .cfg_we  (cfg_we),
      .cfg_map (cfg_map),
      .adr     (cmd.adr),
      .width   (cmd_width)
   );

   wb_master u_master
   (
      .CLK_I   (CLK_I),
      .RST_I   (RST_I),
      .cmd_req (cmd_req),
      .cmd     (cmd),
      .cmd_ack (cmd_ack),
      .rsp     (rsp),
      .width   (cmd_width),
      .m2s     (m2s),
      .s2m     (s2m)
   );

   // Stand-in for the system bus
   wb_sram_slave u_slave
   (
      .CLK_I (CLK_I),
      .RST_I (RST_I),
      .m2s   (m2s),
      .s2m   (s2m)
   );

endmodule

// File: tb/wb_master_asserts.sv
`timescale 1ns/10ps

module wb_master_asserts
(
   input logic            CLK_I,
   input logic            RST_I,
   input logic            cmd_ack,
   input wb_pkg::wb_m2s_t m2s,
   input wb_pkg::wb_s2m_t s2m
);

   // Classic bus rule
   stb_needs_cyc: assert property (@(posedge CLK_I) disable iff (RST_I) m2s.stb |-> m2s.cyc)
      else $error("STB high without CYC");

   // Master comes out of reset idle
   idle_after_reset: assert property (@(posedge CLK_I) $fell(RST_I) |-> !cmd_ack && !m2s.cyc)
      else $error("cmd_ack or CYC high right after reset");

   // ERR or RTY closes the cycle on the next edge
   cyc_drops_on_fault: assert property (@(posedge CLK_I) disable iff (RST_I)
      m2s.stb && (s2m.err || s2m.rty) |=> !m2s.cyc)
      else $error("CYC still high after ERR or RTY");

endmodule

bind wb_master wb_master_asserts u_asserts
(
   .CLK_I   (CLK_I),
   .RST_I   (RST_I),
   .cmd_ack (cmd_ack),
   .m2s     (m2s),
   .s2m     (s2m)
);

// File: tb/tb_wb_subsys.sv
`timescale 1ns/10ps

module tb_wb_subsys;

   // One row of the stimulus table
   typedef struct
   {
      string              name;
      bit                 do_cfg;      // load map before the command
      wb_pkg::width_map_t map;
      wb_pkg::wb_cmd_t    cmd;
      wb_pkg::wb_status_e exp_status;
      bit                 check_rdata;
   } entry_t;

   logic               CLK_I = 1'b0;
   logic               RST_I;
   logic               cfg_we;
   wb_pkg::width_map_t cfg_map;
   logic               cmd_req;
   wb_pkg::wb_cmd_t    cmd;
   logic               cmd_ack;
   wb_pkg::wb_rsp_t    rsp;

   entry_t table_q[$];

   // Memory model, one word per adr[9:2]
   wb_pkg::wb_dat_t ref_mem [wb_pkg::MEM_WORDS];

   // Width map as the config block should hold it
   wb_pkg::width_map_t tb_map;

   int cycles = 0;
   int limit  = 0;

   wb_subsys_top uut
   (
      .CLK_I   (CLK_I),
      .RST_I   (RST_I),
      .cfg_we  (cfg_we),
      .cfg_map (cfg_map),
      .cmd_req (cmd_req),
      .cmd     (cmd),
      .cmd_ack (cmd_ack),
      .rsp     (rsp)
   );

   always #4 CLK_I = ~CLK_I;

   // Watchdog on the whole table
   always @(posedge CLK_I)
   begin
      cycles = cycles + 1;
      if (limit != 0 && cycles > limit)
      begin
         $display("TB FAILED");
         $fatal(1, "Timeout after %0d cycles, a handshake never completed", cycles);
      end
   end

   // Region 0 in the top field
   function automatic wb_pkg::region_w_t region_width(wb_pkg::width_map_t map,
                                                      wb_pkg::wb_adr_t adr);
      return wb_pkg::region_w_t'(map >> (2 * (7 - int'(adr[31:29]))));
   endfunction

   // Narrow ports take lane 0 or lanes 1:0, data replicated
   function automatic void model_write(wb_pkg::region_w_t w, wb_pkg::wb_adr_t adr,
                                       wb_pkg::wb_dat_t dat, wb_pkg::wb_sel_t sel);
      wb_pkg::wb_sel_t lanes;
      wb_pkg::wb_dat_t data;
      wb_pkg::wb_dat_t mask;
      case (w)
         wb_pkg::RW_8:
         begin
            lanes = {3'b000, sel[0]};
            data  = {4{dat[7:0]}};
         end
         wb_pkg::RW_16:
         begin
            lanes = {2'b00, sel[1:0]};
            data  = {2{dat[15:0]}};
         end
         default:
         begin
            lanes = sel;
            data  = dat;
         end
      endcase
      mask = {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
      ref_mem[adr[9:2]] = (ref_mem[adr[9:2]] & ~mask) | (data & mask);
   endfunction

   function automatic void add_entry(string name, wb_pkg::wb_op_e op, wb_pkg::wb_adr_t adr,
                                     wb_pkg::wb_dat_t dat, wb_pkg::wb_sel_t sel, logic last,
                                     wb_pkg::wb_status_e st, bit chk, bit do_cfg = 1'b0,
                                     wb_pkg::width_map_t map = '0);
      entry_t e;
      e.name        = name;
      e.do_cfg      = do_cfg;
      e.map         = map;
      e.cmd         = '{op: op, adr: adr, dat: dat, sel: sel, last: last};
      e.exp_status  = st;
      e.check_rdata = chk;
      table_q.push_back(e);
   endfunction

   task automatic check_value(input string name, input string what,
                              input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp)
      else
      begin
         $display("** Error %s: %s expected %h, actual %h", name, what, exp, act);
         $display("TB FAILED");
         $fatal(1, "%s: wrong %s", name, what);
      end
   endtask

   // Sampled 1 ns after the edge
   task automatic wait_ack(input logic level);
      forever
      begin
         @(posedge CLK_I);
         #1;
         if (cmd_ack === level)
         begin
            break;
         end
      end
   endtask

   task automatic apply_config(input wb_pkg::width_map_t map);
      cfg_map = map;
      cfg_we  = 1'b1;
      @(posedge CLK_I);
      #1;
      cfg_we  = 1'b0;
      tb_map  = map;
   endtask

   task automatic build_table();
      wb_pkg::width_map_t map3;
      wb_pkg::width_map_t map7;
      // Region 3 moved to 32 bits
      map3 = {wb_pkg::RW_32, wb_pkg::RW_16, wb_pkg::RW_32, wb_pkg::RW_32,
              wb_pkg::RW_8, wb_pkg::RW_16, wb_pkg::RW_32, wb_pkg::RW_64};
      // Region 7 moved to 32 bits so the access reaches the slave
      map7 = {wb_pkg::RW_32, wb_pkg::RW_16, wb_pkg::RW_32, wb_pkg::RW_64,
              wb_pkg::RW_8, wb_pkg::RW_16, wb_pkg::RW_32, wb_pkg::RW_32};
      // 32-bit region, partial selects, word 0x10 written twice
      for (int i = 0; i < 3; i++)
      begin
         add_entry($sformatf("wr32_%0d", i), wb_pkg::OP_WRITE, 32'h0000_0010 + 4 * i,
                   $urandom(), 4'($urandom_range(1, 14)), 1'b0, wb_pkg::ST_OK, 1'b0);
      end
      add_entry("wr32_merge", wb_pkg::OP_WRITE, 32'h0000_0010, $urandom(),
                4'($urandom_range(1, 14)), 1'b0, wb_pkg::ST_OK, 1'b0);
      for (int i = 0; i < 3; i++)
      begin
         add_entry($sformatf("rd32_%0d", i), wb_pkg::OP_READ, 32'h0000_0010 + 4 * i,
                   '0, 4'hF, 1'b0, wb_pkg::ST_OK, 1'b1);
      end
      // Narrow regions 4 and 1
      add_entry("wr8", wb_pkg::OP_WRITE, 32'h8000_0040, $urandom(), 4'hF, 1'b0,
                wb_pkg::ST_OK, 1'b0);
      add_entry("rd8", wb_pkg::OP_READ, 32'h8000_0040, '0, 4'hF, 1'b0, wb_pkg::ST_OK, 1'b1);
      add_entry("wr16", wb_pkg::OP_WRITE, 32'h2000_0044, $urandom(), 4'hF, 1'b0,
                wb_pkg::ST_OK, 1'b0);
      add_entry("rd16", wb_pkg::OP_READ, 32'h2000_0044, '0, 4'hF, 1'b0, wb_pkg::ST_OK, 1'b1);
      // Block cycles, last on the fourth beat
      for (int i = 0; i < 4; i++)
      begin
         add_entry($sformatf("blk_wr_%0d", i), wb_pkg::OP_BLK_WRITE, 32'h0000_0080 + 4 * i,
                   $urandom(), 4'hF, i == 3, wb_pkg::ST_OK, 1'b0);
      end
      for (int i = 0; i < 4; i++)
      begin
         add_entry($sformatf("blk_rd_%0d", i), wb_pkg::OP_BLK_READ, 32'h0000_0080 + 4 * i,
                   '0, 4'hF, i == 3, wb_pkg::ST_OK, 1'b1);
      end
      // RMW returns the old word
      add_entry("rmw", wb_pkg::OP_RMW, 32'h0000_0010, $urandom(), 4'b0110, 1'b0,
                wb_pkg::ST_OK, 1'b1);
      add_entry("rmw_rd", wb_pkg::OP_READ, 32'h0000_0010, '0, 4'hF, 1'b0, wb_pkg::ST_OK, 1'b1);
      // Fault regions and a 64-bit region, all aliasing words 4 to 6
      add_entry("err6", wb_pkg::OP_WRITE, {wb_pkg::ERR_REGION, 29'h0000_0014}, $urandom(),
                4'hF, 1'b0, wb_pkg::ST_ERR, 1'b0);
      add_entry("rty7", wb_pkg::OP_READ, {wb_pkg::RTY_REGION, 29'h0000_0018}, '0, 4'hF,
                1'b0, wb_pkg::ST_RTY, 1'b0, 1'b1, map7);
      add_entry("bad64", wb_pkg::OP_WRITE, 32'h6000_0010, $urandom(), 4'hF, 1'b0,
                wb_pkg::ST_BADWIDTH, 1'b0);
      for (int i = 0; i < 3; i++)
      begin
         add_entry($sformatf("keep_%0d", i), wb_pkg::OP_READ, 32'h0000_0010 + 4 * i,
                   '0, 4'hF, 1'b0, wb_pkg::ST_OK, 1'b1);
      end
      // Region 3 reprogrammed, then checked against its alias in region 0
      add_entry("cfg_wr", wb_pkg::OP_WRITE, 32'h6000_0020, $urandom(), 4'hF, 1'b0,
                wb_pkg::ST_OK, 1'b0, 1'b1, map3);
      add_entry("cfg_rd", wb_pkg::OP_READ, 32'h6000_0020, '0, 4'hF, 1'b0, wb_pkg::ST_OK, 1'b1);
      add_entry("cfg_alias", wb_pkg::OP_READ, 32'h0000_0020, '0, 4'hF, 1'b0,
                wb_pkg::ST_OK, 1'b1);
   endtask

   initial
   begin
      entry_t            e;
      wb_pkg::region_w_t w;
      wb_pkg::wb_dat_t   exp_rdata;
      logic              exp_open;
      logic              writes;
      RST_I   = 1'b1;
      cfg_we  = 1'b0;
      cfg_map = wb_pkg::WIDTH_MAP_RST;
      cmd_req = 1'b0;
      cmd     = '0;
      void'($urandom(46659));
      tb_map = wb_pkg::WIDTH_MAP_RST;
      foreach (ref_mem[i])
      begin
         ref_mem[i] = '0;
      end
      build_table();
      limit = 60 * table_q.size() + 8;
      repeat (8) @(posedge CLK_I);
      #1;
      RST_I = 1'b0;
      foreach (table_q[i])
      begin
         e = table_q[i];
         if (e.do_cfg)
         begin
            apply_config(e.map);
         end
         w         = region_width(tb_map, e.cmd.adr);
         exp_rdata = ref_mem[e.cmd.adr[9:2]];
         // Block beat without last leaves CYC open
         exp_open  = (e.cmd.op == wb_pkg::OP_BLK_READ || e.cmd.op == wb_pkg::OP_BLK_WRITE) &&
                     !e.cmd.last && e.exp_status == wb_pkg::ST_OK;
         writes    = e.cmd.op == wb_pkg::OP_WRITE || e.cmd.op == wb_pkg::OP_BLK_WRITE ||
                     e.cmd.op == wb_pkg::OP_RMW;
         cmd       = e.cmd;
         cmd_req   = 1'b1;
         wait_ack(1'b1);
         check_value(e.name, "status", 32'(e.exp_status), 32'(rsp.status));
         if (e.check_rdata)
         begin
            check_value(e.name, "rdata", exp_rdata, rsp.rdata);
         end
         cmd_req = 1'b0;
         wait_ack(1'b0);
         check_value(e.name, "cyc", 32'(exp_open), 32'(uut.m2s.cyc));
         // Faults and rejects leave memory alone
         if (writes && e.exp_status == wb_pkg::ST_OK)
         begin
            model_write(w, e.cmd.adr, e.cmd.dat, e.cmd.sel);
         end
      end
      $display("TB PASSED");
      $finish;
   end

endmodule

// File: filelist.f
common/wb_pkg.sv
wb_master/wb_region_cfg.sv
wb_master/wb_master.sv
verilog/wb_sram_slave.sv
verilog/wb_subsys_top.sv
tb/wb_master_asserts.sv
tb/tb_wb_subsys.sv

// File: Makefile
# Verilator build of the WISHBONE master subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_wb_subsys
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(wildcard common/*.sv wb_master/*.sv verilog/*.sv tb/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a nonzero exit status
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
